/* verilog/wbuf_pkg.sv */
// word, byte mask and entry types shared by the write buffer RTL and its testbench
package wbuf_pkg;

  // bytes in one data word
  parameter int BytesPerWord = 8;
  // data word width in bits
  parameter int DataW = 64;
  // word address width in bits
  parameter int WordAddrW = 29;

  typedef logic [WordAddrW-1:0]    word_addr_t;
  typedef logic [BytesPerWord-1:0] byte_mask_t;
  typedef logic [DataW-1:0]        data_t;

  // each byte of an entry is in one of four states, as valid/dirty/txblock
  //   000 free
  //   110 written and waiting to be sent
  //   101 part of a write in flight
  //   111 in flight and overwritten since
  //       drops back to 110 when its write returns
  typedef struct packed {
    word_addr_t addr;
    byte_mask_t valid;
    byte_mask_t dirty;
    byte_mask_t txblock;
    data_t      data;
  } wbuf_entry_t;

endpackage

/* verilog/wbuf_ifs.sv */
// interfaces between the store acceptance, the entry store and the transmit side
`timescale 1ns/10ps

//////////////////////////////////////////////////////////////////////
// fill path, store request into the entry array
//////////////////////////////////////////////////////////////////////

interface wbuf_fill_if #(
  parameter int Depth = 8
);
  localparam int PtrW = $clog2(Depth);

  // entry views for the address match
  wbuf_pkg::byte_mask_t [Depth-1:0] valid;
  wbuf_pkg::word_addr_t [Depth-1:0] addr;
  // one-cycle merge strobe and its payload
  logic                 wr_en;
  logic [PtrW-1:0]      wr_ptr;
  wbuf_pkg::word_addr_t wr_addr;
  wbuf_pkg::byte_mask_t wr_be;
  wbuf_pkg::data_t      wr_data;

  modport store (
    input  wr_en, wr_ptr, wr_addr, wr_be, wr_data,
    output valid, addr
  );
  modport writer (
    input  valid, addr,
    output wr_en, wr_ptr, wr_addr, wr_be, wr_data
  );
endinterface

//////////////////////////////////////////////////////////////////////
// drain path, sends and retires against the entry array
//////////////////////////////////////////////////////////////////////

interface wbuf_drain_if #(
  parameter int Depth = 8
);
  localparam int PtrW = $clog2(Depth);

  wbuf_pkg::wbuf_entry_t [Depth-1:0] entries;
  // accepted memory write
  logic                 send_en;
  logic [PtrW-1:0]      send_ptr;
  wbuf_pkg::byte_mask_t send_be;
  // returned memory write
  logic                 retire_en;
  logic [PtrW-1:0]      retire_ptr;
  wbuf_pkg::byte_mask_t retire_be;

  modport store (
    input  send_en, send_ptr, send_be, retire_en, retire_ptr, retire_be,
    output entries
  );
  modport issuer (
    input  entries,
    output send_en, send_ptr, send_be
  );
  // the slot table records pointer and mask of each accepted write
  modport tracker (
    input  send_ptr, send_be,
    output retire_en, retire_ptr, retire_be
  );
endinterface

/* verilog/wbuf_write_accept.sv */
// store acceptance, matches the request address and picks the entry that takes its bytes
`timescale 1ns/10ps

module wbuf_write_accept #(
  parameter int Depth = 8
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 req_valid_i,
  input  wbuf_pkg::word_addr_t req_addr_i,
  input  wbuf_pkg::byte_mask_t req_be_i,
  input  wbuf_pkg::data_t      req_wdata_i,
  output logic                 req_gnt_o,
  wbuf_fill_if.writer          fill
);
  localparam int PtrW = $clog2(Depth);

  logic [Depth-1:0] hit_oh;
  logic [Depth-1:0] free;
  logic [PtrW-1:0]  hit_ptr;
  logic [PtrW-1:0]  free_ptr;
  logic             hit;

  //////////////////////////////////////////////////////////////////////
  // address match and free entry search
  //////////////////////////////////////////////////////////////////////

  // an entry with no valid byte is free, its stale address is ignored
  for (genvar k = 0; k < Depth; k++) begin : gen_match
    assign free[k]   = ~(|fill.valid[k]);
    assign hit_oh[k] = ~free[k] && (fill.addr[k] == req_addr_i);
  end

  always_comb begin : p_search
    hit_ptr  = '0;
    free_ptr = '0;
    // walk downwards so the lowest free entry wins
    for (int k = Depth-1; k >= 0; k--) begin
      if (free[k])
        free_ptr = PtrW'(k);
    end
    // match is one-hot, OR of the indices encodes it
    for (int k = 0; k < Depth; k++) begin
      if (hit_oh[k])
        hit_ptr = hit_ptr | PtrW'(k);
    end
  end

  assign hit = |hit_oh;

  //////////////////////////////////////////////////////////////////////
  // grant and merge request
  //////////////////////////////////////////////////////////////////////

  // a match always wins over a free entry, so one address never sits twice
  assign req_gnt_o    = req_valid_i && (hit || (|free));
  assign fill.wr_en   = req_gnt_o;
  assign fill.wr_ptr  = hit ? hit_ptr : free_ptr;
  assign fill.wr_addr = req_addr_i;
  assign fill.wr_be   = req_be_i;
  assign fill.wr_data = req_wdata_i;

  // relies on the store never holding one word address in two entries
  a_hit_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_valid_i |-> $onehot0(hit_oh))
    else $error("[wbuf] request address matches more than one entry");

endmodule

/* verilog/wbuf_entry_store.sv */
// entry registers of the write buffer, applies retire, send and merge to the byte states
`timescale 1ns/10ps

module wbuf_entry_store #(
  parameter int Depth = 8
) (
  input  logic          clk_i,
  input  logic          rst_ni,
  wbuf_fill_if.store    fill,
  wbuf_drain_if.store   drain,
  output logic          empty_o
);
  localparam int Bytes = wbuf_pkg::BytesPerWord;
  localparam int ByteW = wbuf_pkg::DataW / Bytes;

  // per-byte state
  wbuf_pkg::byte_mask_t [Depth-1:0] valid_q, valid_d;
  wbuf_pkg::byte_mask_t [Depth-1:0] dirty_q, dirty_d;
  wbuf_pkg::byte_mask_t [Depth-1:0] txblk_q, txblk_d;
  // payload
  wbuf_pkg::word_addr_t [Depth-1:0] addr_q;
  wbuf_pkg::data_t      [Depth-1:0] data_q;

  //////////////////////////////////////////////////////////////////////
  // state update
  //////////////////////////////////////////////////////////////////////

  // send never hits an entry with bytes in flight, and retire only hits those,
  // so the two touch different entries in one cycle
  always_comb begin : p_state
    valid_d = valid_q;
    dirty_d = dirty_q;
    txblk_d = txblk_q;

    // returned write, clean bytes go free and overwritten ones wait again
    if (drain.retire_en) begin
      txblk_d[drain.retire_ptr] = txblk_q[drain.retire_ptr] & ~drain.retire_be;
      valid_d[drain.retire_ptr] = valid_q[drain.retire_ptr] &
                                  ~(drain.retire_be & ~dirty_q[drain.retire_ptr]);
    end

    // accepted write, sent bytes move from dirty to in flight
    if (drain.send_en) begin
      dirty_d[drain.send_ptr] = dirty_q[drain.send_ptr] & ~drain.send_be;
      txblk_d[drain.send_ptr] = txblk_q[drain.send_ptr] | drain.send_be;
    end

    // merge comes last
    // writing an in-flight byte gives 111
    if (fill.wr_en) begin
      valid_d[fill.wr_ptr] = valid_d[fill.wr_ptr] | fill.wr_be;
      dirty_d[fill.wr_ptr] = dirty_d[fill.wr_ptr] | fill.wr_be;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_state_regs
    if (!rst_ni) begin
      valid_q <= '0;
      dirty_q <= '0;
      txblk_q <= '0;
    end else begin
      valid_q <= valid_d;
      dirty_q <= dirty_d;
      txblk_q <= txblk_d;
    end
  end

  // address and enabled data bytes
  always_ff @(posedge clk_i) begin : p_payload
    if (fill.wr_en) begin
      addr_q[fill.wr_ptr] <= fill.wr_addr;
      for (int b = 0; b < Bytes; b++) begin
        if (fill.wr_be[b])
          data_q[fill.wr_ptr][b*ByteW +: ByteW] <= fill.wr_data[b*ByteW +: ByteW];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // entry views
  //////////////////////////////////////////////////////////////////////

  assign fill.valid = valid_q;
  assign fill.addr  = addr_q;
  assign empty_o    = ~(|valid_q);

  for (genvar k = 0; k < Depth; k++) begin : gen_entry
    assign drain.entries[k] = '{
      addr:    addr_q[k],
      valid:   valid_q[k],
      dirty:   dirty_q[k],
      txblock: txblk_q[k],
      data:    data_q[k]
    };

    // holds only if issuer, tracker and memory keep send and retire paired
    for (genvar b = 0; b < Bytes; b++) begin : gen_byte_chk
      a_byte_state: assert property (@(posedge clk_i) disable iff (!rst_ni)
        {valid_q[k][b], dirty_q[k][b], txblk_q[k][b]}
          inside {3'b000, 3'b110, 3'b101, 3'b111})
        else $error("[wbuf] entry %0d byte %0d in illegal state", k, b);
    end
  end

endmodule

/* verilog/wbuf_tx_issue.sv */
// transmit side, picks a sendable entry round-robin and drives the memory write request
`timescale 1ns/10ps

module wbuf_tx_issue #(
  parameter int Depth = 8,
  parameter int MaxTx = 4
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  wbuf_drain_if.issuer             drain,
  input  logic                     slot_free_i,
  input  logic [$clog2(MaxTx)-1:0] tx_id_i,
  output logic                     send_en_o,
  output logic                     mem_req_o,
  input  logic                     mem_ack_i,
  output wbuf_pkg::word_addr_t     mem_addr_o,
  output wbuf_pkg::byte_mask_t     mem_be_o,
  output wbuf_pkg::data_t          mem_wdata_o,
  output logic [$clog2(MaxTx)-1:0] mem_id_o
);
  localparam int PtrW = $clog2(Depth);

  logic [Depth-1:0] sendable;
  logic [PtrW-1:0]  rr_q;
  logic [PtrW-1:0]  sel_ptr;

  //////////////////////////////////////////////////////////////////////
  // round-robin pick
  //////////////////////////////////////////////////////////////////////

  // no second write to a word while one is in flight
  // the memory may reorder them
  for (genvar k = 0; k < Depth; k++) begin : gen_sendable
    assign sendable[k] = (|drain.entries[k].dirty) && !(|drain.entries[k].txblock);
  end

  // first sendable entry at or after the pointer
  always_comb begin : p_pick
    logic [PtrW-1:0] idx;
    sel_ptr = rr_q;
    for (int i = Depth-1; i >= 0; i--) begin
      idx = rr_q + PtrW'(i);
      if (sendable[idx])
        sel_ptr = idx;
    end
  end

  // a waiting request parks the pointer on its entry
  // that entry stays sendable until its own send
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_rr
    if (!rst_ni) begin
      rr_q <= '0;
    end else if (mem_req_o) begin
      rr_q <= mem_ack_i ? sel_ptr + 1'b1 : sel_ptr;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // memory request
  //////////////////////////////////////////////////////////////////////

  assign mem_req_o   = (|sendable) && slot_free_i;
  assign mem_addr_o  = drain.entries[sel_ptr].addr;
  assign mem_be_o    = drain.entries[sel_ptr].dirty;
  assign mem_wdata_o = drain.entries[sel_ptr].data;
  assign mem_id_o    = tx_id_i;

  assign send_en_o      = mem_req_o && mem_ack_i;
  assign drain.send_en  = send_en_o;
  assign drain.send_ptr = sel_ptr;
  assign drain.send_be  = mem_be_o;

  // address and ID hold while the request waits
  // a merge into the entry may only add bytes, which then go out with this write
  a_req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_o && !mem_ack_i |=>
      mem_req_o && $stable(mem_addr_o) && $stable(mem_id_o) &&
      (($past(mem_be_o) & ~mem_be_o) == '0))
    else $error("[wbuf] memory request changed while waiting for ack");

endmodule

/* verilog/wbuf_tx_tracker.sv */
// transaction slot table and return queue, turns write acknowledgements into entry retires
`timescale 1ns/10ps

module wbuf_tx_tracker #(
  parameter int Depth = 8,
  parameter int MaxTx = 4
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  wbuf_drain_if.tracker            drain,
  input  logic                     send_en_i,
  output logic                     slot_free_o,
  output logic [$clog2(MaxTx)-1:0] tx_id_o,
  input  logic                     mem_rtrn_vld_i,
  input  logic [$clog2(MaxTx)-1:0] mem_rtrn_id_i
);
  localparam int PtrW = $clog2(Depth);
  localparam int IdW  = $clog2(MaxTx);

  // slot table, one row per transaction ID
  logic [MaxTx-1:0]                 slot_vld_q, slot_vld_d;
  logic [MaxTx-1:0][PtrW-1:0]       slot_ptr_q;
  wbuf_pkg::byte_mask_t [MaxTx-1:0] slot_be_q;
  logic [IdW-1:0]                   id_q, id_d;

  // return queue, pointers carry one extra wrap bit
  logic [MaxTx-1:0][IdW-1:0] rtrn_mem_q;
  logic [IdW:0]              rtrn_wr_q, rtrn_rd_q;
  logic                      rtrn_empty;
  logic [IdW-1:0]            rtrn_id;

  //////////////////////////////////////////////////////////////////////
  // retire from the queue head
  //////////////////////////////////////////////////////////////////////

  // no more than MaxTx IDs are ever outstanding, so the queue cannot overflow
  assign rtrn_empty = (rtrn_wr_q == rtrn_rd_q);
  assign rtrn_id    = rtrn_mem_q[rtrn_rd_q[IdW-1:0]];

  assign drain.retire_en  = ~rtrn_empty;
  assign drain.retire_ptr = slot_ptr_q[rtrn_id];
  assign drain.retire_be  = slot_be_q[rtrn_id];

  //////////////////////////////////////////////////////////////////////
  // slot allocation and ID choice
  //////////////////////////////////////////////////////////////////////

  always_comb begin : p_slots
    slot_vld_d = slot_vld_q;
    if (!rtrn_empty)
      slot_vld_d[rtrn_id] = 1'b0;
    if (send_en_i)
      slot_vld_d[id_q] = 1'b1;

    // offered ID stays put while its slot is free, so a waiting request keeps it
    // otherwise move to the lowest free slot
    id_d = id_q;
    if (slot_vld_d[id_q]) begin
      for (int i = MaxTx-1; i >= 0; i--) begin
        if (!slot_vld_d[i])
          id_d = IdW'(i);
      end
    end
  end

  assign slot_free_o = ~slot_vld_q[id_q];
  assign tx_id_o     = id_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ctrl
    if (!rst_ni) begin
      slot_vld_q <= '0;
      id_q       <= '0;
      rtrn_wr_q  <= '0;
      rtrn_rd_q  <= '0;
    end else begin
      slot_vld_q <= slot_vld_d;
      id_q       <= id_d;
      if (mem_rtrn_vld_i)
        rtrn_wr_q <= rtrn_wr_q + 1'b1;
      // one retire per cycle
      if (!rtrn_empty)
        rtrn_rd_q <= rtrn_rd_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin : p_payload
    if (send_en_i) begin
      slot_ptr_q[id_q] <= drain.send_ptr;
      slot_be_q[id_q]  <= drain.send_be;
    end
    if (mem_rtrn_vld_i)
      rtrn_mem_q[rtrn_wr_q[IdW-1:0]] <= mem_rtrn_id_i;
  end

  // the memory only returns IDs that were handed out and not yet retired
  a_rtrn_slot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_rtrn_vld_i |-> slot_vld_q[mem_rtrn_id_i])
    else $error("[wbuf] return for unused transaction ID %0d", mem_rtrn_id_i);

endmodule

/* verilog/coal_wbuf.sv */
// top level of the coalescing write buffer, store port in and out-of-order memory writes out
`timescale 1ns/10ps

module coal_wbuf #(
  parameter int Depth = 8,
  parameter int MaxTx = 4
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // store port
  input  logic                     req_valid_i,
  input  wbuf_pkg::word_addr_t     req_addr_i,
  input  wbuf_pkg::byte_mask_t     req_be_i,
  input  wbuf_pkg::data_t          req_wdata_i,
  output logic                     req_gnt_o,
  output logic                     empty_o,
  // memory write port
  output logic                     mem_req_o,
  input  logic                     mem_ack_i,
  output wbuf_pkg::word_addr_t     mem_addr_o,
  output wbuf_pkg::byte_mask_t     mem_be_o,
  output wbuf_pkg::data_t          mem_wdata_o,
  output logic [$clog2(MaxTx)-1:0] mem_id_o,
  // write acknowledgements
  input  logic                     mem_rtrn_vld_i,
  input  logic [$clog2(MaxTx)-1:0] mem_rtrn_id_i
);
  logic                     slot_free;
  logic [$clog2(MaxTx)-1:0] tx_id;
  logic                     send_en;

  wbuf_fill_if  #(.Depth(Depth)) fill_if  ();
  wbuf_drain_if #(.Depth(Depth)) drain_if ();

  wbuf_write_accept #(
    .Depth (Depth)
  ) u_write_accept (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (req_valid_i),
    .req_addr_i  (req_addr_i),
    .req_be_i    (req_be_i),
    .req_wdata_i (req_wdata_i),
    .req_gnt_o   (req_gnt_o),
    .fill        (fill_if.writer)
  );

  wbuf_entry_store #(
    .Depth (Depth)
  ) u_entry_store (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .fill    (fill_if.store),
    .drain   (drain_if.store),
    .empty_o (empty_o)
  );

  wbuf_tx_issue #(
    .Depth (Depth),
    .MaxTx (MaxTx)
  ) u_tx_issue (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .drain       (drain_if.issuer),
    .slot_free_i (slot_free),
    .tx_id_i     (tx_id),
    .send_en_o   (send_en),
    .mem_req_o   (mem_req_o),
    .mem_ack_i   (mem_ack_i),
    .mem_addr_o  (mem_addr_o),
    .mem_be_o    (mem_be_o),
    .mem_wdata_o (mem_wdata_o),
    .mem_id_o    (mem_id_o)
  );

  wbuf_tx_tracker #(
    .Depth (Depth),
    .MaxTx (MaxTx)
  ) u_tx_tracker (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .drain          (drain_if.tracker),
    .send_en_i      (send_en),
    .slot_free_o    (slot_free),
    .tx_id_o        (tx_id),
    .mem_rtrn_vld_i (mem_rtrn_vld_i),
    .mem_rtrn_id_i  (mem_rtrn_id_i)
  );

endmodule

/* sim/tb_wbuf_model.svh */
// byte image model, LFSR and compare task, included inside the write buffer testbench module
`ifndef TB_WBUF_MODEL_SVH
`define TB_WBUF_MODEL_SVH

//////////////////////////////////////////////////////////////////////
// store address pool and byte images
//////////////////////////////////////////////////////////////////////

localparam int PoolSize = 12;

// latest value of each byte stored, and which bytes were ever stored
wbuf_pkg::data_t      img_q     [PoolSize];
wbuf_pkg::byte_mask_t written_q [PoolSize];
// last value of each byte seen on an accepted memory write
wbuf_pkg::data_t      sent_q    [PoolSize];

logic [31:0] lfsr_q = 32'h41a5_bbc0;
int          errors = 0;
int          checks = 0;
string       cur_test = "none";

// spread the pool over the address space, no two alike
function automatic wbuf_pkg::word_addr_t pool_addr(input int i);
  return wbuf_pkg::word_addr_t'(29'h0040_0000 + i * 29'h0011_0203);
endfunction

function automatic int pool_index(input wbuf_pkg::word_addr_t addr);
  for (int i = 0; i < PoolSize; i++) begin
    if (pool_addr(i) == addr)
      return i;
  end
  return -1;
endfunction

// one byte enable widened to eight data bits
function automatic wbuf_pkg::data_t byte_bits(input wbuf_pkg::byte_mask_t m);
  wbuf_pkg::data_t d;
  for (int b = 0; b < wbuf_pkg::BytesPerWord; b++)
    d[b*8 +: 8] = {8{m[b]}};
  return d;
endfunction

//////////////////////////////////////////////////////////////////////
// random bits
//////////////////////////////////////////////////////////////////////

// fibonacci form, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// one step per bit taken
function logic [31:0] rand_bits(input int n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    lfsr_q = lfsr_next(lfsr_q);
    v      = {v[30:0], lfsr_q[0]};
  end
  return v;
endfunction

//////////////////////////////////////////////////////////////////////
// compare and model updates
//////////////////////////////////////////////////////////////////////

task check_value(input string label, input logic [63:0] exp, input logic [63:0] act);
  checks++;
  if (exp !== act) begin
    errors++;
    $display("[ERROR] %s %s expected %h actual %h", cur_test, label, exp, act);
  end
endtask

// granted store, newest bytes win
task merge_store(input wbuf_pkg::word_addr_t addr, input wbuf_pkg::byte_mask_t be,
                 input wbuf_pkg::data_t data);
  int idx;
  idx = pool_index(addr);
  img_q[idx]     = (img_q[idx] & ~byte_bits(be)) | (data & byte_bits(be));
  written_q[idx] = written_q[idx] | be;
endtask

// accepted memory write, every enabled byte must be the latest stored one
task record_send(input wbuf_pkg::word_addr_t addr, input wbuf_pkg::byte_mask_t be,
                 input wbuf_pkg::data_t data);
  int idx;
  idx = pool_index(addr);
  if (idx < 0) begin
    errors++;
    $display("%s memory write to address %h that was never stored", cur_test, addr);
  end else begin
    check_value($sformatf("write data addr %h be %h", addr, be),
                img_q[idx] & byte_bits(be), data & byte_bits(be));
    sent_q[idx] = (sent_q[idx] & ~byte_bits(be)) | (data & byte_bits(be));
  end
endtask

`endif

/* sim/tb_coal_wbuf.sv */
// simulation top that drives random stores into the write buffer and models the memory
`timescale 1ns/10ps

module tb_coal_wbuf;

  localparam int Depth      = 8;
  localparam int MaxTx      = 4;
  localparam int IdW        = $clog2(MaxTx);
  localparam int RandCycles = 3000;
  // reset, first store, full buffer, random phase
  localparam int StimCycles = 5 + 1 + 9 + RandCycles;
  localparam int CycleLimit = 4 * StimCycles + 200;

  logic                 clk_i;
  logic                 rst_ni;
  logic                 req_valid_i;
  wbuf_pkg::word_addr_t req_addr_i;
  wbuf_pkg::byte_mask_t req_be_i;
  wbuf_pkg::data_t      req_wdata_i;
  logic                 req_gnt_o;
  logic                 empty_o;
  logic                 mem_req_o;
  logic                 mem_ack_i;
  wbuf_pkg::word_addr_t mem_addr_o;
  wbuf_pkg::byte_mask_t mem_be_o;
  wbuf_pkg::data_t      mem_wdata_o;
  logic [IdW-1:0]       mem_id_o;
  logic                 mem_rtrn_vld_i;
  logic [IdW-1:0]       mem_rtrn_id_i;

  // writes taken by the memory and not yet returned
  logic [IdW-1:0]       out_id   [$];
  wbuf_pkg::word_addr_t out_addr [$];
  int cycles   = 0;
  int tests    = 0;
  int err_mark = 0;

  `include "tb_wbuf_model.svh"

  coal_wbuf #(
    .Depth (Depth),
    .MaxTx (MaxTx)
  ) u_coal_wbuf (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_valid_i    (req_valid_i),
    .req_addr_i     (req_addr_i),
    .req_be_i       (req_be_i),
    .req_wdata_i    (req_wdata_i),
    .req_gnt_o      (req_gnt_o),
    .empty_o        (empty_o),
    .mem_req_o      (mem_req_o),
    .mem_ack_i      (mem_ack_i),
    .mem_addr_o     (mem_addr_o),
    .mem_be_o       (mem_be_o),
    .mem_wdata_o    (mem_wdata_o),
    .mem_id_o       (mem_id_o),
    .mem_rtrn_vld_i (mem_rtrn_vld_i),
    .mem_rtrn_id_i  (mem_rtrn_id_i)
  );

  initial begin : p_clk
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin : p_watchdog
    cycles++;
    if (cycles >= CycleLimit) begin
      $display("timeout after %0d cycles, the buffer never drained", cycles);
      $display("** FAIL **");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // one clock cycle of stimulus and observation
  //////////////////////////////////////////////////////////////////////

  task accept_write();
    logic dup_addr;
    logic dup_id;
    dup_addr = 1'b0;
    dup_id   = 1'b0;
    foreach (out_id[k]) begin
      dup_addr = dup_addr | (out_addr[k] == mem_addr_o);
      dup_id   = dup_id | (out_id[k] == mem_id_o);
    end
    check_value("address already in flight", 64'd0, 64'(dup_addr));
    check_value("transaction ID still outstanding", 64'd0, 64'(dup_id));
    record_send(mem_addr_o, mem_be_o, mem_wdata_o);
    out_id.push_back(mem_id_o);
    out_addr.push_back(mem_addr_o);
  endtask

  // inputs change on the falling edge and outputs are read 1 ns later
  task run_cycle(input logic vld, input wbuf_pkg::word_addr_t addr,
                 input wbuf_pkg::byte_mask_t be, input wbuf_pkg::data_t data,
                 input logic ack_on, output logic gnt);
    logic [31:0] r32;
    int          k;
    @(negedge clk_i);
    req_valid_i = vld;
    req_addr_i  = addr;
    req_be_i    = be;
    req_wdata_i = data;
    r32         = rand_bits(2);
    mem_ack_i   = ack_on && (r32[1:0] != 2'b00);
    // return one outstanding write picked at random
    mem_rtrn_vld_i = 1'b0;
    r32 = rand_bits(2);
    if (out_id.size() > 0 && r32[1:0] == 2'b00) begin
      r32            = rand_bits(8);
      k              = int'(r32[7:0]) % out_id.size();
      mem_rtrn_vld_i = 1'b1;
      mem_rtrn_id_i  = out_id[k];
      out_id.delete(k);
      out_addr.delete(k);
    end
    #1;
    gnt = req_gnt_o;
    // a write sent now carries the entry as it was before this cycle's merge
    if (mem_req_o && mem_ack_i)
      accept_write();
    if (vld && gnt)
      merge_store(addr, be, data);
  endtask

  task make_payload(output wbuf_pkg::byte_mask_t be, output wbuf_pkg::data_t data);
    logic [31:0] r32;
    logic [31:0] lo;
    r32  = rand_bits(8);
    be   = (r32[7:0] == 8'h00) ? 8'h01 : r32[7:0];
    lo   = rand_bits(32);
    r32  = rand_bits(32);
    data = {r32, lo};
  endtask

  task report_test();
    tests++;
    if (errors == err_mark)
      $display("test %s: ok", cur_test);
    else
      $display("test %s: %0d errors", cur_test, errors - err_mark);
  endtask

  //////////////////////////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////////////////////////

  task test_reset();
    wbuf_pkg::byte_mask_t be;
    wbuf_pkg::data_t      d;
    logic                 gnt;
    cur_test = "reset";
    err_mark = errors;
    check_value("empty_o", 64'd1, 64'(empty_o));
    check_value("mem_req_o", 64'd0, 64'(mem_req_o));
    make_payload(be, d);
    run_cycle(1'b1, pool_addr(0), be, d, 1'b0, gnt);
    check_value("first store grant", 64'd1, 64'(gnt));
    report_test();
  endtask

  // memory holds off and entry 0 already holds the store of the reset test
  task test_full();
    wbuf_pkg::byte_mask_t be;
    wbuf_pkg::data_t      d;
    logic                 gnt;
    cur_test = "full";
    err_mark = errors;
    for (int i = 1; i < Depth; i++) begin
      make_payload(be, d);
      run_cycle(1'b1, pool_addr(i), be, d, 1'b0, gnt);
      check_value($sformatf("grant to new address %0d", i), 64'd1, 64'(gnt));
    end
    make_payload(be, d);
    run_cycle(1'b1, pool_addr(Depth), be, d, 1'b0, gnt);
    check_value("grant with buffer full", 64'd0, 64'(gnt));
    make_payload(be, d);
    run_cycle(1'b1, pool_addr(3), be, d, 1'b0, gnt);
    check_value("grant to buffered address", 64'd1, 64'(gnt));
    report_test();
  endtask

  task test_random();
    wbuf_pkg::word_addr_t a;
    wbuf_pkg::byte_mask_t be;
    wbuf_pkg::data_t      d;
    logic                 pend;
    logic                 gnt;
    logic [31:0]          r32;
    cur_test = "random";
    err_mark = errors;
    pend     = 1'b0;
    for (int n = 0; n < RandCycles; n++) begin
      // a refused store is held until granted
      if (!pend) begin
        r32  = rand_bits(3);
        pend = (r32[2:0] < 3'd5);
        r32  = rand_bits(4);
        a    = pool_addr(int'(r32[3:0]) % PoolSize);
        make_payload(be, d);
      end
      run_cycle(pend, a, be, d, 1'b1, gnt);
      if (gnt)
        pend = 1'b0;
    end
    report_test();
  endtask

  task test_drain();
    logic gnt;
    cur_test = "drain";
    err_mark = errors;
    while (!(empty_o && out_id.size() == 0))
      run_cycle(1'b0, '0, '0, '0, 1'b1, gnt);
    for (int i = 0; i < PoolSize; i++) begin
      check_value($sformatf("final image addr %0d", i),
                  img_q[i] & byte_bits(written_q[i]), sent_q[i] & byte_bits(written_q[i]));
    end
    report_test();
  endtask

  initial begin : p_main
    rst_ni         = 1'b0;
    req_valid_i    = 1'b0;
    req_addr_i     = '0;
    req_be_i       = '0;
    req_wdata_i    = '0;
    mem_ack_i      = 1'b0;
    mem_rtrn_vld_i = 1'b0;
    mem_rtrn_id_i  = '0;
    for (int i = 0; i < PoolSize; i++) begin
      img_q[i]     = '0;
      written_q[i] = '0;
      sent_q[i]    = '0;
    end
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    #1;
    test_reset();
    test_full();
    test_random();
    test_drain();
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

/* flist.f */
+incdir+sim
verilog/wbuf_pkg.sv
verilog/wbuf_ifs.sv
verilog/wbuf_write_accept.sv
verilog/wbuf_entry_store.sv
verilog/wbuf_tx_issue.sv
verilog/wbuf_tx_tracker.sv
verilog/coal_wbuf.sv
sim/tb_coal_wbuf.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the write buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tb_coal_wbuf \
  -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out="$(./obj_dir/sim_tb)"
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qxF -- '** PASS **'; then
  exit 0
fi
exit 1
